// ==== common/mult_pkg.sv ====
package mult_pkg;

    localparam int OPERAND_W  = 16;
    localparam int PRODUCT_W  = 2 * OPERAND_W;
    localparam int NUM_DIGITS = OPERAND_W / 2;    // Radix-4, two bits per digit.
    localparam int NUM_ROWS   = NUM_DIGITS + 1;   // Digit rows plus the hot-one row.

    typedef logic signed [OPERAND_W-1:0] operand_t;
    typedef logic signed [PRODUCT_W-1:0] product_t;

    // Encoded as {neg, select_2m, select_m}.
    typedef enum logic [2:0] {
        DIGIT_ZERO     = 3'b000,
        DIGIT_PLUS_M   = 3'b001,
        DIGIT_PLUS_2M  = 3'b010,
        DIGIT_MINUS_2M = 3'b110,
        DIGIT_MINUS_M  = 3'b101
    } booth_digit_e;

    typedef booth_digit_e [NUM_DIGITS-1:0] digits_t;

    // Row NUM_ROWS-1 holds the negation correction ones.
    typedef product_t [NUM_ROWS-1:0] pp_rows_t;

endpackage

// ==== booth/booth_recoder.sv ====
`timescale 1ns/100ps

module booth_recoder (
    input  mult_pkg::operand_t multiplier,
    output mult_pkg::digits_t  digits
);

    logic [mult_pkg::OPERAND_W:0] padded;

    assign padded = {multiplier, 1'b0};   // Implicit zero below bit 0.

    always_comb begin
        logic [2:0] trip;
        logic       sel_m;
        logic       sel_2m;
        logic       neg;
        for (int i = 0; i < mult_pkg::NUM_DIGITS; i++) begin
            trip   = padded[2*i +: 3];
            sel_m  = trip[0] ^ trip[1];
            sel_2m = ~(sel_m | ~(trip[1] ^ trip[2]));
            // 111 selects nothing, so it stays a plain zero.
            neg    = trip[2] & (sel_m | sel_2m);
            digits[i] = mult_pkg::booth_digit_e'({neg, sel_2m, sel_m});
        end
    end

endmodule

// ==== booth/partial_product_gen.sv ====
`timescale 1ns/100ps

module partial_product_gen (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    output logic               in_ready,
    input  mult_pkg::operand_t multiplicand,
    input  mult_pkg::operand_t multiplier,
    output logic               rows_valid,
    input  logic               rows_ready,
    output mult_pkg::pp_rows_t rows
);

    localparam int EXT_W = mult_pkg::PRODUCT_W - mult_pkg::OPERAND_W - 1;

    mult_pkg::digits_t  digits;
    mult_pkg::pp_rows_t rows_d;

    booth_recoder booth_recoder_inst (
        .multiplier (multiplier),
        .digits     (digits)
    );

    always_comb begin
        logic [mult_pkg::OPERAND_W:0] mag;
        logic [mult_pkg::OPERAND_W:0] sel;
        logic                         neg;
        rows_d = '0;
        for (int i = 0; i < mult_pkg::NUM_DIGITS; i++) begin
            case (digits[i])
                mult_pkg::DIGIT_PLUS_M, mult_pkg::DIGIT_MINUS_M:
                    mag = {multiplicand[mult_pkg::OPERAND_W-1], multiplicand};
                mult_pkg::DIGIT_PLUS_2M, mult_pkg::DIGIT_MINUS_2M:
                    mag = {multiplicand, 1'b0};
                default:
                    mag = '0;
            endcase
            neg = digits[i] inside {mult_pkg::DIGIT_MINUS_M, mult_pkg::DIGIT_MINUS_2M};
            sel = neg ? ~mag : mag;   // One's complement, hot one added below.
            rows_d[i] = {{EXT_W{sel[mult_pkg::OPERAND_W]}}, sel} << (2 * i);
            rows_d[mult_pkg::NUM_ROWS-1][2*i] = neg;
        end
    end

    assign in_ready = ~rows_valid | rows_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            rows_valid <= 1'b0;
        end else if (in_ready) begin
            rows_valid <= in_valid;
        end
    end

    // Payload only moves on a transfer.
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            rows <= rows_d;
        end
    end

    // A stalled stage must present the same item on the next cycle.
    rows_hold_a : assert property (
        @(posedge clk) disable iff (rst)
        rows_valid && !rows_ready |=> rows_valid && $stable(rows)
    );

endmodule

// ==== verilog/csa_tree.sv ====
`timescale 1ns/100ps

module csa_tree (
    input  logic               clk,
    input  logic               rst,
    input  logic               rows_valid,
    output logic               rows_ready,
    input  mult_pkg::pp_rows_t rows,
    output logic               vec_valid,
    input  logic               vec_ready,
    output mult_pkg::product_t sum_vec,
    output mult_pkg::product_t carry_vec
);

    mult_pkg::product_t lvl1 [6];   // 9 to 6.
    mult_pkg::product_t lvl2 [4];   // 6 to 4.
    mult_pkg::product_t lvl3 [3];   // 4 to 3.
    mult_pkg::product_t sum_d;
    mult_pkg::product_t carry_d;

    function automatic mult_pkg::product_t csa_sum(
        input mult_pkg::product_t a,
        input mult_pkg::product_t b,
        input mult_pkg::product_t c
    );
        return a ^ b ^ c;
    endfunction

    // Carry moves up one column, the top bit falls off.
    function automatic mult_pkg::product_t csa_carry(
        input mult_pkg::product_t a,
        input mult_pkg::product_t b,
        input mult_pkg::product_t c
    );
        return ((a & b) | (a & c) | (b & c)) << 1;
    endfunction

    for (genvar g = 0; g < 3; g++) begin : gen_lvl1
        assign lvl1[2*g]   = csa_sum(rows[3*g], rows[3*g+1], rows[3*g+2]);
        assign lvl1[2*g+1] = csa_carry(rows[3*g], rows[3*g+1], rows[3*g+2]);
    end

    assign lvl2[0] = csa_sum(lvl1[0], lvl1[1], lvl1[2]);
    assign lvl2[1] = csa_carry(lvl1[0], lvl1[1], lvl1[2]);
    assign lvl2[2] = csa_sum(lvl1[3], lvl1[4], lvl1[5]);
    assign lvl2[3] = csa_carry(lvl1[3], lvl1[4], lvl1[5]);

    assign lvl3[0] = csa_sum(lvl2[0], lvl2[1], lvl2[2]);
    assign lvl3[1] = csa_carry(lvl2[0], lvl2[1], lvl2[2]);
    assign lvl3[2] = lvl2[3];   // Passes through this level.

    assign sum_d   = csa_sum(lvl3[0], lvl3[1], lvl3[2]);
    assign carry_d = csa_carry(lvl3[0], lvl3[1], lvl3[2]);

    assign rows_ready = ~vec_valid | vec_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            vec_valid <= 1'b0;
        end else if (rows_ready) begin
            vec_valid <= rows_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rows_valid && rows_ready) begin
            sum_vec   <= sum_d;
            carry_vec <= carry_d;
        end
    end

    vec_valid_known_a : assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(vec_valid)
    );

endmodule

// ==== verilog/final_adder.sv ====
`timescale 1ns/100ps

module final_adder (
    input  logic               clk,
    input  logic               rst,
    input  logic               vec_valid,
    output logic               vec_ready,
    input  mult_pkg::product_t sum_vec,
    input  mult_pkg::product_t carry_vec,
    output logic               out_valid,
    input  logic               out_ready,
    output mult_pkg::product_t product
);

    mult_pkg::product_t product_d;

    assign product_d = sum_vec + carry_vec;   // Wraps modulo 2^32.

    assign vec_ready = ~out_valid | out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (vec_ready) begin
            out_valid <= vec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (vec_valid && vec_ready) begin
            product <= product_d;
        end
    end

    product_hold_a : assert property (
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(product)
    );

endmodule

// ==== verilog/booth_multiplier.sv ====
`timescale 1ns/100ps

module booth_multiplier (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    output logic               in_ready,
    input  mult_pkg::operand_t multiplicand,
    input  mult_pkg::operand_t multiplier,
    output logic               out_valid,
    input  logic               out_ready,
    output mult_pkg::product_t product
);

    logic               rows_valid;
    logic               rows_ready;
    mult_pkg::pp_rows_t rows;
    logic               vec_valid;
    logic               vec_ready;
    mult_pkg::product_t sum_vec;
    mult_pkg::product_t carry_vec;

    // Stage 1.
    partial_product_gen partial_product_gen_inst (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .rows_valid   (rows_valid),
        .rows_ready   (rows_ready),
        .rows         (rows)
    );

    // Stage 2.
    csa_tree csa_tree_inst (
        .clk        (clk),
        .rst        (rst),
        .rows_valid (rows_valid),
        .rows_ready (rows_ready),
        .rows       (rows),
        .vec_valid  (vec_valid),
        .vec_ready  (vec_ready),
        .sum_vec    (sum_vec),
        .carry_vec  (carry_vec)
    );

    // Stage 3.
    final_adder final_adder_inst (
        .clk       (clk),
        .rst       (rst),
        .vec_valid (vec_valid),
        .vec_ready (vec_ready),
        .sum_vec   (sum_vec),
        .carry_vec (carry_vec),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .product   (product)
    );

endmodule

// ==== dv/booth_multiplier_tb.sv ====
`timescale 1ns/100ps

module booth_multiplier_tb;

    localparam int TIMEOUT_CYCLES = 100;
    localparam int RANDOM_ITEMS   = 300;

    logic               clk;
    logic               rst;
    logic               in_valid;
    logic               in_ready;
    mult_pkg::operand_t multiplicand;
    mult_pkg::operand_t multiplier;
    logic               out_valid;
    logic               out_ready;
    mult_pkg::product_t product;

    int                 seed = 44318;
    int                 ready_seed;
    int                 errors = 0;
    int                 exp_count = 0;
    mult_pkg::product_t exp_head = '0;
    mult_pkg::product_t exp_q [$];
    logic               steady_mode;
    logic               bp_mode;

    booth_multiplier booth_multiplier_inst (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .product      (product)
    );

    always #4 clk = ~clk;

    // Reference model queue with one entry per accepted input.
    always @(posedge clk) begin
        if (rst) begin
            exp_q.delete();
        end else begin
            if (out_valid && out_ready && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(mult_pkg::product_t'(multiplicand)
                                * mult_pkg::product_t'(multiplier));
            end
        end
        exp_count = exp_q.size();
        exp_head  = (exp_count > 0) ? exp_q[0] : '0;
    end

    // Output back-pressure stays low through reset.
    always @(posedge clk) begin
        logic in_reset;
        in_reset = rst;
        #1;
        if (in_reset) begin
            out_ready = 1'b0;
        end else if (bp_mode) begin
            out_ready = ($random(ready_seed) & 1) != 0;
        end else begin
            out_ready = 1'b1;
        end
    end

    product_value_a : assert property (
        @(posedge clk) disable iff (rst)
        out_valid && out_ready && exp_count > 0 |-> product == exp_head
    ) else begin
        errors++;
        $display("Mismatch product expected %h actual %h",
                 $sampled(exp_head), $sampled(product));
    end

    no_extra_output_a : assert property (
        @(posedge clk) disable iff (rst)
        out_valid && out_ready |-> exp_count > 0
    ) else begin
        errors++;
        $display("Output transfer with no input pending");
    end

    stall_hold_a : assert property (
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(product)
    ) else begin
        errors++;
        $display("Product or out_valid changed while the output was stalled");
    end

    full_only_a : assert property (
        @(posedge clk) disable iff (rst)
        !in_ready |-> exp_count == 3
    ) else begin
        errors++;
        $display("in_ready low with %0d items in flight", $sampled(exp_count));
    end

    latency_a : assert property (
        @(posedge clk) disable iff (rst)
        steady_mode && in_valid && in_ready |-> ##3 out_valid
    ) else begin
        errors++;
        $display("out_valid missing three cycles after an input transfer");
    end

    // Nothing may come out early from an empty pipeline.
    latency_exact_a : assert property (
        @(posedge clk) disable iff (rst)
        steady_mode && in_valid && in_ready && exp_count == 0 |=> !out_valid ##1 !out_valid
    ) else begin
        errors++;
        $display("out_valid rose earlier than three cycles after an input transfer");
    end

    reset_state_a : assert property (
        @(posedge clk)
        $past(rst) |-> !out_valid && in_ready
    ) else begin
        errors++;
        $display("out_valid high or in_ready low during or right after reset");
    end

    function automatic mult_pkg::operand_t rand_operand();
        logic [31:0] r;
        r = $random(seed);
        return r[15:0];
    endfunction

    task automatic stop_on_timeout(input string what);
        $display("Timeout waiting for %s", what);
        $display("Errors: %0d", errors + 1);
        $display("Checks failed");
        $finish;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(posedge clk);
        #1;
    endtask

    // Starts 1 ns after an edge and returns 1 ns after the transfer edge.
    task automatic send(input mult_pkg::operand_t a, input mult_pkg::operand_t b);
        int waited;
        waited       = 0;
        multiplicand = a;
        multiplier   = b;
        in_valid     = 1'b1;
        #2;
        while (!in_ready && waited < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #3;
            waited++;
        end
        if (!in_ready) begin
            stop_on_timeout("in_ready");
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_count != 0 && waited < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_count != 0) begin
            stop_on_timeout("the pipeline to drain");
        end
    endtask

    // Covers every digit type and the correction row.
    task automatic run_corners();
        send(16'sh8000, 16'sh8000);
        send(16'sh8000, 16'sh7fff);
        send(16'sh7fff, 16'sh7fff);
        send(16'sh7fff, 16'sh8000);
        send(16'sh0000, 16'sh4c3b);
        send(16'sh2d17, 16'sh0000);
        send(16'shffff, 16'shffff);
        send(16'sh1357, 16'sh5555);
        send(16'shb6e1, 16'shaaaa);
        send(16'sh8000, 16'shaaaa);
        send(16'sh7fff, 16'sh5555);
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        in_valid     = 1'b0;
        multiplicand = '0;
        multiplier   = '0;
        out_ready    = 1'b0;
        steady_mode  = 1'b0;
        bp_mode      = 1'b0;
        ready_seed   = seed + 1;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        steady_mode = 1'b1;
        send(16'sh1234, 16'sh0003);
        wait_drain();
        send(16'shf00d, 16'sh7ace);
        wait_drain();
        run_corners();   // Back to back.
        wait_drain();
        for (int i = 0; i < 16; i++) begin
            send(rand_operand(), rand_operand());
        end
        wait_drain();
        steady_mode = 1'b0;

        bp_mode = 1'b1;
        for (int i = 0; i < RANDOM_ITEMS; i++) begin
            send(rand_operand(), rand_operand());
            if (($random(seed) & 3) == 0) begin
                idle(1);
            end
        end
        bp_mode = 1'b0;
        wait_drain();
        idle(2);

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
common/mult_pkg.sv
booth/booth_recoder.sv
booth/partial_product_gen.sv
verilog/csa_tree.sv
verilog/final_adder.sv
verilog/booth_multiplier.sv
dv/booth_multiplier_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= booth_multiplier_tb
FILELIST   ?= compile.f
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j 0
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   := All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
